/* gpu_core.f */
gpu_core_pkg.sv
simt_lane.sv
vector_reg_file.sv
instruction_decoder.sv
instruction_fetcher.sv
warp_scheduler.sv
gpu_core.sv
tb_gpu_core.sv

/* gpu_core.sv */
`timescale 1ns/1ps

module gpu_core import gpu_core_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start,
    input  logic [$bits(warp_id_t):0]     num_warps,
    input  imem_addr_t                    base_address,
    output logic                          done,
    output logic [WARP_COUNT-1:0]         instr_read_valid,
    output imem_addr_t                    instr_read_address [WARP_COUNT],
    input  logic [WARP_COUNT-1:0]         instr_read_ready,
    input  instruction_t                  instr_read_data [WARP_COUNT],
    output logic [LANE_COUNT-1:0]         mem_write_valid,
    output data_t                         mem_write_address [LANE_COUNT],
    output data_t                         mem_write_data [LANE_COUNT],
    input  logic [LANE_COUNT-1:0]         mem_write_ready
);

    warp_state_t  warp_state [WARP_COUNT];
    imem_addr_t   pc [WARP_COUNT];
    warp_id_t     current_warp;
    fetch_state_t fetch_state [WARP_COUNT];
    instruction_t instruction [WARP_COUNT];

    opcode_t      opcode [WARP_COUNT];
    reg_addr_t    rd [WARP_COUNT];
    reg_addr_t    rs1 [WARP_COUNT];
    reg_addr_t    rs2 [WARP_COUNT];
    data_t        imm [WARP_COUNT];

    data_t        rs1_data [WARP_COUNT][LANE_COUNT];
    data_t        rs2_data [WARP_COUNT][LANE_COUNT];
    data_t        alu_result [LANE_COUNT];
    logic [LANE_COUNT-1:0] store_busy;

    logic lane_execute;

    assign lane_execute = (warp_state[current_warp] == WARP_EXECUTE);

    warp_scheduler i_warp_scheduler (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .num_warps   (num_warps),
        .base_address(base_address),
        .fetch_state (fetch_state),
        .opcode      (opcode),
        .store_busy  (store_busy),
        .warp_state  (warp_state),
        .pc          (pc),
        .current_warp(current_warp),
        .done        (done)
    );

    for (genvar w = 0; w < WARP_COUNT; w++) begin : g_warp
        logic write_enable;

        // Only the current warp commits results, and only arithmetic ops write back
        assign write_enable = (current_warp == warp_id_t'(w)) &&
                              (warp_state[w] == WARP_EXECUTE) &&
                              (opcode[w] inside {OP_ADD, OP_SUB, OP_MUL, OP_AND, OP_ADDI});

        instruction_fetcher i_instruction_fetcher (
            .clk               (clk),
            .reset             (reset),
            .warp_state        (warp_state[w]),
            .pc                (pc[w]),
            .instr_read_ready  (instr_read_ready[w]),
            .instr_read_data   (instr_read_data[w]),
            .instr_read_valid  (instr_read_valid[w]),
            .instr_read_address(instr_read_address[w]),
            .fetch_state       (fetch_state[w]),
            .instruction       (instruction[w])
        );

        instruction_decoder i_instruction_decoder (
            .clk        (clk),
            .reset      (reset),
            .warp_state (warp_state[w]),
            .instruction(instruction[w]),
            .opcode     (opcode[w]),
            .rd         (rd[w]),
            .rs1        (rs1[w]),
            .rs2        (rs2[w]),
            .imm        (imm[w])
        );

        vector_reg_file i_vector_reg_file (
            .clk         (clk),
            .reset       (reset),
            .warp_id     (warp_id_t'(w)),
            .write_enable(write_enable),
            .rd          (rd[w]),
            .rs1         (rs1[w]),
            .rs2         (rs2[w]),
            .result      (alu_result),
            .rs1_data    (rs1_data[w]),
            .rs2_data    (rs2_data[w])
        );
    end

    // Shared lanes see the operands of whichever warp is current
    for (genvar l = 0; l < LANE_COUNT; l++) begin : g_lane
        simt_lane i_simt_lane (
            .clk              (clk),
            .reset            (reset),
            .execute          (lane_execute),
            .opcode           (opcode[current_warp]),
            .op1              (rs1_data[current_warp][l]),
            .op2              (rs2_data[current_warp][l]),
            .imm              (imm[current_warp]),
            .mem_write_ready  (mem_write_ready[l]),
            .alu_result       (alu_result[l]),
            .mem_write_valid  (mem_write_valid[l]),
            .mem_write_address(mem_write_address[l]),
            .mem_write_data   (mem_write_data[l]),
            .store_busy       (store_busy[l])
        );
    end

endmodule

/* gpu_core_pkg.sv */
package gpu_core_pkg;

    localparam int WARP_COUNT = 2;
    localparam int LANE_COUNT = 4;
    localparam int DATA_WIDTH = 16;
    localparam int REG_COUNT = 16;
    localparam int IMEM_ADDR_WIDTH = 8;

    // Read-only id registers inside each thread's register set
    localparam int WARP_ID_REG = 14;
    localparam int THREAD_ID_REG = 15;

    // Data words double as data memory addresses
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [IMEM_ADDR_WIDTH-1:0] imem_addr_t;

    // opcode 15:12, rd 11:8, rs1 7:4, rs2 or immediate 3:0
    typedef logic [15:0] instruction_t;
    typedef logic [$clog2(REG_COUNT)-1:0] reg_addr_t;
    typedef logic [$clog2(WARP_COUNT)-1:0] warp_id_t;

    typedef enum logic [3:0] {
        OP_ADD   = 4'd0,
        OP_SUB   = 4'd1,
        OP_MUL   = 4'd2,
        OP_AND   = 4'd3,
        OP_ADDI  = 4'd4,
        OP_STORE = 4'd5,
        OP_HALT  = 4'd15
    } opcode_t;

    typedef enum logic [2:0] {
        WARP_IDLE,
        WARP_FETCH,
        WARP_DECODE,
        WARP_EXECUTE,
        WARP_STORE_WAIT,
        WARP_UPDATE,
        WARP_DONE
    } warp_state_t;

    typedef enum logic [1:0] {FETCH_IDLE, FETCH_REQUEST, FETCH_DONE} fetch_state_t;

    typedef enum logic {STORE_IDLE, STORE_REQUEST} store_state_t;

endpackage

/* gpu_core_trace.txt */
# C num_warps base_address | P imem_address instruction (one program, shared by all warps)
# E store_address store_data, one line per expected lane store, all values hex
C 2 20
P 20 01EE
P 21 0111
P 22 011F
P 23 42F3
P 24 2322
P 25 133E
P 26 5013
P 27 3432
P 28 4518
P 29 5054
P 2A 7123
P 2B F000
E 3 0009
E 4 0010
E 5 0019
E 6 0024
E 7 0008
E 8 000F
E 9 0018
E A 0023
E C 0001
E D 0000
E E 0001
E F 0004
E 10 0000
E 11 0004
E 12 0000
E 13 0002

/* instruction_decoder.sv */
`timescale 1ns/1ps

module instruction_decoder import gpu_core_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  warp_state_t  warp_state,
    input  instruction_t instruction,
    output opcode_t      opcode,
    output reg_addr_t    rd,
    output reg_addr_t    rs1,
    output reg_addr_t    rs2,
    output data_t        imm
);

    opcode_t   next_opcode;
    reg_addr_t next_rd;

    always_comb begin
        case (instruction[15:12])
            OP_ADD, OP_SUB, OP_MUL, OP_AND, OP_ADDI, OP_STORE, OP_HALT: begin
                next_opcode = opcode_t'(instruction[15:12]);
                next_rd = instruction[11:8];
            end
            default: begin
                // Unknown code becomes an add into r0, which drops the write
                next_opcode = OP_ADD;
                next_rd = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            opcode <= OP_ADD;
            rd <= '0;
            rs1 <= '0;
            rs2 <= '0;
            imm <= '0;
        end else if (warp_state == WARP_DECODE) begin
            opcode <= next_opcode;
            rd <= next_rd;
            rs1 <= instruction[7:4];
            rs2 <= instruction[3:0];
            imm <= data_t'(instruction[3:0]);
        end
    end

endmodule

/* instruction_fetcher.sv */
`timescale 1ns/1ps

module instruction_fetcher import gpu_core_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  warp_state_t  warp_state,
    input  imem_addr_t   pc,
    input  logic         instr_read_ready,
    input  instruction_t instr_read_data,
    output logic         instr_read_valid,
    output imem_addr_t   instr_read_address,
    output fetch_state_t fetch_state,
    output instruction_t instruction
);

    logic request_start;
    logic transfer;

    assign request_start = (fetch_state == FETCH_IDLE) && (warp_state == WARP_FETCH);
    assign transfer = instr_read_valid && instr_read_ready;
    assign instr_read_valid = (fetch_state == FETCH_REQUEST);

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_state <= FETCH_IDLE;
        end else begin
            case (fetch_state)
                FETCH_IDLE:    if (request_start) fetch_state <= FETCH_REQUEST;
                FETCH_REQUEST: if (transfer) fetch_state <= FETCH_DONE;
                // Hold the word until the scheduler has moved the warp on
                FETCH_DONE:    if (warp_state != WARP_FETCH) fetch_state <= FETCH_IDLE;
                default:       fetch_state <= FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (request_start) instr_read_address <= pc;
        if (transfer) instruction <= instr_read_data;
    end

    a_fetch_hold: assert property (@(posedge clk) disable iff (reset)
        (instr_read_valid && !instr_read_ready) |=>
            (instr_read_valid && $stable(instr_read_address)));

endmodule

/* simt_lane.sv */
`timescale 1ns/1ps

module simt_lane import gpu_core_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    execute,
    input  opcode_t opcode,
    input  data_t   op1,
    input  data_t   op2,
    input  data_t   imm,
    input  logic    mem_write_ready,
    output data_t   alu_result,
    output logic    mem_write_valid,
    output data_t   mem_write_address,
    output data_t   mem_write_data,
    output logic    store_busy
);

    store_state_t store_state;
    logic         store_load;

    always_comb begin
        case (opcode)
            OP_ADD:  alu_result = op1 + op2;
            OP_SUB:  alu_result = op1 - op2;
            // Only the low half of the product is kept
            OP_MUL:  alu_result = op1 * op2;
            OP_AND:  alu_result = op1 & op2;
            OP_ADDI: alu_result = op1 + imm;
            default: alu_result = '0;
        endcase
    end

    assign store_load = execute && (opcode == OP_STORE) && (store_state == STORE_IDLE);
    assign mem_write_valid = (store_state == STORE_REQUEST);
    assign store_busy = (store_state == STORE_REQUEST);

    always_ff @(posedge clk) begin
        if (reset) begin
            store_state <= STORE_IDLE;
        end else begin
            case (store_state)
                STORE_IDLE:    if (store_load) store_state <= STORE_REQUEST;
                STORE_REQUEST: if (mem_write_ready) store_state <= STORE_IDLE;
                default:       store_state <= STORE_IDLE;
            endcase
        end
    end

    // Address is rs1 plus the 4-bit field, data is the rs2 register value
    always_ff @(posedge clk) begin
        if (store_load) begin
            mem_write_address <= op1 + imm;
            mem_write_data <= op2;
        end
    end

    a_store_hold: assert property (@(posedge clk) disable iff (reset)
        (mem_write_valid && !mem_write_ready) |=>
            (mem_write_valid && $stable(mem_write_address) && $stable(mem_write_data)));

endmodule

/* tb_gpu_core.sv */
`timescale 1ns/1ps

module tb_gpu_core import gpu_core_pkg::*; ();

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      start;
    logic [$bits(warp_id_t):0] num_warps;
    imem_addr_t                base_address;
    logic                      done;
    logic [WARP_COUNT-1:0]     instr_read_valid;
    imem_addr_t                instr_read_address [WARP_COUNT];
    logic [WARP_COUNT-1:0]     instr_read_ready;
    instruction_t              instr_read_data [WARP_COUNT];
    logic [LANE_COUNT-1:0]     mem_write_valid;
    data_t                     mem_write_address [LANE_COUNT];
    data_t                     mem_write_data [LANE_COUNT];
    logic [LANE_COUNT-1:0]     mem_write_ready;

    integer       seed = 86986;
    instruction_t imem [256];
    data_t        exp_addr [32];
    data_t        exp_data [32];
    int           write_count [32];
    int           exp_count = 0;
    int           prog_words = 0;
    int           cfg_warps = 0;
    int           cfg_base = 0;
    logic         trace_loaded = 1'b0;
    logic         done_seen = 1'b0;

    // Test index 0 reset, 1 fetch, 2 store data, 3 store coverage, 4 write hold, 5 done
    int test_checks [6];
    int test_errors [6];

    imem_addr_t next_fetch [WARP_COUNT];
    imem_addr_t fetch_held [WARP_COUNT];
    logic       fetch_waiting [WARP_COUNT];
    int         fetch_count [WARP_COUNT];
    data_t      write_held_addr [LANE_COUNT];
    data_t      write_held_data [LANE_COUNT];
    logic       write_waiting [LANE_COUNT];

    gpu_core i_gpu_core (
        .clk               (clk),
        .reset             (reset),
        .start             (start),
        .num_warps         (num_warps),
        .base_address      (base_address),
        .done              (done),
        .instr_read_valid  (instr_read_valid),
        .instr_read_address(instr_read_address),
        .instr_read_ready  (instr_read_ready),
        .instr_read_data   (instr_read_data),
        .mem_write_valid   (mem_write_valid),
        .mem_write_address (mem_write_address),
        .mem_write_data    (mem_write_data),
        .mem_write_ready   (mem_write_ready)
    );

    always #50 clk = ~clk;

    task automatic check_data(input int test, input string name, input data_t got,
                              input data_t expected);
        test_checks[test]++;
        if (got !== expected) begin
            test_errors[test]++;
            $display("[FAIL] %0d ns %s: got %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic check_state(input int test, input string name, input logic got,
                               input logic expected);
        test_checks[test]++;
        if (got !== expected) begin
            test_errors[test]++;
            $display("[FAIL] %0d ns %s: got %b, expected %b", $time, name, got, expected);
        end
    endtask

    task automatic report_error(input int test, input string msg);
        test_checks[test]++;
        test_errors[test]++;
        $display("Error at %0d ns: %s", $time, msg);
    endtask

    task automatic load_trace();
        int fd;
        int code;
        int kind;
        int ch;
        int a;
        int b;
        logic finished;
        fd = $fopen("gpu_core_trace.txt", "r");
        if (fd == 0) begin
            report_error(0, "could not open gpu_core_trace.txt");
        end else begin
            // Unlisted words read as a halt tagged with their own address
            for (int i = 0; i < 256; i++) imem[i] = {8'hF0, i[7:0]};
            finished = 1'b0;
            while (!finished) begin
                code = $fscanf(fd, " %c", kind);
                if (code != 1) begin
                    finished = 1'b1;
                end else if (kind == "#") begin
                    do ch = $fgetc(fd); while (ch != 10 && ch != -1);
                end else begin
                    code = $fscanf(fd, "%h %h", a, b);
                    if (code != 2) begin
                        report_error(0, "malformed line in trace file");
                        finished = 1'b1;
                    end else begin
                        case (kind)
                            "C": begin
                                cfg_warps = a;
                                cfg_base = b;
                            end
                            "P": begin
                                imem[a[7:0]] = b[15:0];
                                prog_words++;
                            end
                            "E": begin
                                exp_addr[exp_count] = a[15:0];
                                exp_data[exp_count] = b[15:0];
                                write_count[exp_count] = 0;
                                exp_count++;
                            end
                            default: report_error(0, "unknown line kind in trace file");
                        endcase
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic record_store(input int lane, input data_t addr, input data_t data);
        int hit;
        hit = -1;
        for (int i = 0; i < exp_count; i++) begin
            if (exp_addr[i] == addr) hit = i;
        end
        if (hit < 0) begin
            report_error(2, $sformatf("lane %0d stored to unexpected address %h", lane, addr));
        end else begin
            write_count[hit]++;
            if (write_count[hit] > 1)
                report_error(3, $sformatf("address %h was written more than once", addr));
            check_data(2, $sformatf("mem_write_data[%0d]", lane), data, exp_data[hit]);
        end
    endtask

    task automatic print_test(input int test, input string name);
        $display("%-14s %0d checks, %0d errors", name, test_checks[test], test_errors[test]);
    endtask

    // Instruction ready only answers a visible request
    always @(posedge clk) begin : drive_memory
        int rnd;
        for (int w = 0; w < WARP_COUNT; w++) begin
            rnd = $random(seed);
            instr_read_ready[w] <= instr_read_valid[w] && rnd[0];
            instr_read_data[w] <= imem[instr_read_address[w]];
        end
        for (int l = 0; l < LANE_COUNT; l++) begin
            rnd = $random(seed);
            mem_write_ready[l] <= rnd[0];
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            for (int w = 0; w < WARP_COUNT; w++) begin
                if (instr_read_valid[w]) begin
                    if (fetch_waiting[w])
                        check_data(1, "instr_read_address held", data_t'(instr_read_address[w]),
                                   data_t'(fetch_held[w]));
                    if (instr_read_ready[w]) begin
                        check_data(1, "instr_read_address", data_t'(instr_read_address[w]),
                                   data_t'(next_fetch[w]));
                        next_fetch[w] = next_fetch[w] + 1'b1;
                        fetch_count[w]++;
                        fetch_waiting[w] = 1'b0;
                    end else begin
                        fetch_waiting[w] = 1'b1;
                        fetch_held[w] = instr_read_address[w];
                    end
                end else if (fetch_waiting[w]) begin
                    report_error(1, $sformatf("warp %0d dropped its fetch before ready", w));
                    fetch_waiting[w] = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            for (int l = 0; l < LANE_COUNT; l++) begin
                if (mem_write_valid[l]) begin
                    if (write_waiting[l]) begin
                        check_data(4, "mem_write_address", mem_write_address[l],
                                   write_held_addr[l]);
                        check_data(4, "mem_write_data", mem_write_data[l], write_held_data[l]);
                    end
                    if (mem_write_ready[l]) begin
                        record_store(l, mem_write_address[l], mem_write_data[l]);
                        write_waiting[l] = 1'b0;
                    end else begin
                        write_waiting[l] = 1'b1;
                        write_held_addr[l] = mem_write_address[l];
                        write_held_data[l] = mem_write_data[l];
                    end
                end else if (write_waiting[l]) begin
                    report_error(4, $sformatf("lane %0d dropped its store before ready", l));
                    write_waiting[l] = 1'b0;
                end
            end
        end
    end

    // Done must stay up once it has risen
    always @(posedge clk) begin
        if (!reset) begin
            if (done_seen) check_state(5, "done", done, 1'b1);
            if (done === 1'b1) done_seen = 1'b1;
        end
    end

    initial begin : watchdog
        int limit;
        wait (trace_loaded);
        limit = 200 * prog_words * cfg_warps + 100;
        repeat (limit) @(posedge clk);
        $display("Timeout: done did not rise within %0d cycles", limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : main
        int total_checks;
        int total_errors;
        reset = 1'b1;
        start = 1'b0;
        num_warps = '0;
        base_address = '0;
        instr_read_ready = '0;
        mem_write_ready = '0;
        for (int w = 0; w < WARP_COUNT; w++) begin
            instr_read_data[w] = '0;
            fetch_waiting[w] = 1'b0;
            fetch_count[w] = 0;
        end
        for (int l = 0; l < LANE_COUNT; l++) write_waiting[l] = 1'b0;
        for (int t = 0; t < 6; t++) begin
            test_checks[t] = 0;
            test_errors[t] = 0;
        end
        load_trace();
        for (int w = 0; w < WARP_COUNT; w++) next_fetch[w] = imem_addr_t'(cfg_base);
        trace_loaded = 1'b1;

        // Outputs stay quiet through reset and until start
        for (int i = 0; i < 11; i++) begin
            @(posedge clk);
            if (i == 9) reset <= 1'b0;
            @(negedge clk);
            check_state(0, "done", done, 1'b0);
            check_state(0, "instr_read_valid", |instr_read_valid, 1'b0);
            check_state(0, "mem_write_valid", |mem_write_valid, 1'b0);
        end
        print_test(0, "reset");

        @(posedge clk);
        start <= 1'b1;
        num_warps <= cfg_warps[$bits(warp_id_t):0];
        base_address <= imem_addr_t'(cfg_base);
        @(posedge clk);
        start <= 1'b0;

        while (done !== 1'b1) @(posedge clk);
        @(negedge clk);
        // Every expected store has landed by the time done rises
        for (int i = 0; i < exp_count; i++)
            check_data(3, $sformatf("write count at %h", exp_addr[i]),
                       data_t'(write_count[i]), 16'd1);
        repeat (20) @(posedge clk);
        @(negedge clk);
        for (int w = 0; w < WARP_COUNT; w++)
            check_data(1, $sformatf("fetch count warp %0d", w), data_t'(fetch_count[w]),
                       (w < cfg_warps) ? data_t'(prog_words) : 16'd0);

        print_test(1, "fetch order");
        print_test(2, "store data");
        print_test(3, "store coverage");
        print_test(4, "write hold");
        print_test(5, "done");
        total_checks = 0;
        total_errors = 0;
        for (int t = 0; t < 6; t++) begin
            total_checks += test_checks[t];
            total_errors += test_errors[t];
        end
        $display("Total: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* vector_reg_file.sv */
`timescale 1ns/1ps

module vector_reg_file import gpu_core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  warp_id_t  warp_id,
    input  logic      write_enable,
    input  reg_addr_t rd,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  data_t     result [LANE_COUNT],
    output data_t     rs1_data [LANE_COUNT],
    output data_t     rs2_data [LANE_COUNT]
);

    data_t regs [LANE_COUNT][REG_COUNT];
    logic  writable;

    // r0 and the two id registers are fixed
    assign writable = write_enable && (rd != '0) &&
                      (int'(rd) != WARP_ID_REG) && (int'(rd) != THREAD_ID_REG);

    function automatic data_t read_reg(int lane, reg_addr_t addr);
        data_t value;
        if (addr == '0)
            value = '0;
        else if (int'(addr) == WARP_ID_REG)
            value = data_t'(warp_id);
        else if (int'(addr) == THREAD_ID_REG)
            value = data_t'(lane);
        else
            value = regs[lane][addr];
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int l = 0; l < LANE_COUNT; l++) begin
                for (int r = 0; r < REG_COUNT; r++) begin
                    regs[l][r] <= '0;
                end
            end
        end else if (writable) begin
            // All lanes are always active
            for (int l = 0; l < LANE_COUNT; l++) begin
                regs[l][rd] <= result[l];
            end
        end
    end

    always_comb begin
        for (int l = 0; l < LANE_COUNT; l++) begin
            rs1_data[l] = read_reg(l, rs1);
            rs2_data[l] = read_reg(l, rs2);
        end
    end

endmodule

/* warp_scheduler.sv */
`timescale 1ns/1ps

module warp_scheduler import gpu_core_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  logic [$bits(warp_id_t):0] num_warps,
    input  imem_addr_t                base_address,
    input  fetch_state_t              fetch_state [WARP_COUNT],
    input  opcode_t                   opcode [WARP_COUNT],
    input  logic [LANE_COUNT-1:0]     store_busy,
    output warp_state_t               warp_state [WARP_COUNT],
    output imem_addr_t                pc [WARP_COUNT],
    output warp_id_t                  current_warp,
    output logic                      done
);

    logic [WARP_COUNT-1:0] active;
    logic                  core_idle;
    logic                  all_done;
    warp_id_t              next_warp;

    // Warps that can use the lanes right now
    function automatic logic schedulable(warp_state_t s);
        return s inside {WARP_DECODE, WARP_EXECUTE, WARP_STORE_WAIT, WARP_UPDATE};
    endfunction

    always_comb begin
        core_idle = 1'b1;
        all_done = |active;
        for (int i = 0; i < WARP_COUNT; i++) begin
            if (warp_state[i] != WARP_IDLE) core_idle = 1'b0;
            if (active[i] && warp_state[i] != WARP_DONE) all_done = 1'b0;
        end
    end

    // Walk backwards so the nearest warp in round-robin order wins
    always_comb begin
        next_warp = current_warp;
        for (int k = WARP_COUNT - 1; k >= 1; k--) begin
            if (schedulable(warp_state[(int'(current_warp) + k) % WARP_COUNT]))
                next_warp = warp_id_t'((int'(current_warp) + k) % WARP_COUNT);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= '0;
            current_warp <= '0;
            done <= 1'b0;
            for (int i = 0; i < WARP_COUNT; i++) begin
                warp_state[i] <= WARP_IDLE;
                pc[i] <= '0;
            end
        end else if (start && core_idle) begin
            current_warp <= '0;
            for (int i = 0; i < WARP_COUNT; i++) begin
                if (i < num_warps) begin
                    active[i] <= 1'b1;
                    warp_state[i] <= WARP_FETCH;
                    pc[i] <= base_address;
                end
            end
        end else begin
            done <= done || all_done;

            if (warp_state[current_warp] inside {WARP_UPDATE, WARP_DONE})
                current_warp <= next_warp;

            for (int i = 0; i < WARP_COUNT; i++) begin
                // Fetch completes in parallel, the rest only for the current warp
                if (warp_state[i] == WARP_FETCH) begin
                    if (fetch_state[i] == FETCH_DONE) warp_state[i] <= WARP_DECODE;
                end else if (warp_id_t'(i) == current_warp) begin
                    case (warp_state[i])
                        WARP_DECODE: warp_state[i] <= WARP_EXECUTE;
                        WARP_EXECUTE: begin
                            warp_state[i] <= (opcode[i] == OP_STORE) ? WARP_STORE_WAIT
                                                                     : WARP_UPDATE;
                        end
                        WARP_STORE_WAIT: begin
                            if (!(|store_busy)) warp_state[i] <= WARP_UPDATE;
                        end
                        WARP_UPDATE: begin
                            if (opcode[i] == OP_HALT) begin
                                warp_state[i] <= WARP_DONE;
                            end else begin
                                pc[i] <= pc[i] + 1'b1;
                                warp_state[i] <= WARP_FETCH;
                            end
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    // Round-robin must never land on a warp that was not launched
    a_current_warp_active: assert property (@(posedge clk) disable iff (reset)
        (|active && !done) |-> active[current_warp]);

endmodule
